// ==== files.f ====
design/bench_pkg.sv
design/dataset_banks.sv
design/run_fsm.sv
design/step_counter.sv
design/lane_multiply.sv
design/xor_fold_tree.sv
design/bench_top.sv
tests/tb_bench.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_bench -f files.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "build failed, see $build_log"
    exit 1
fi

./obj_dir/Vtb_bench > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "TESTBENCH FAILED" "$sim_log"; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$sim_log"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== tests/bench_vectors.hex ====
// per run: lane mask, A words, B words (lane-major, 16 per lane), 16 expected nibbles
// A word is 0x{lane}{index}, B is one multiplier per lane
// run 1
ff
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000
1000000 1000000 1000000 1000000 1000000 1000000 1000000 1000000
1000000 1000000 1000000 1000000 1000000 1000000 1000000 1000000
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000
20000000 20000000 20000000 20000000 20000000 20000000 20000000 20000000
20000000 20000000 20000000 20000000 20000000 20000000 20000000 20000000
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
5 a 8 a c a 8 a 5 b 9 b d b 9 b
// run 2, lanes 0 2 3 5 6
6d
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
100 100 100 100 100 100 100 100 100 100 100 100 100 100 100 100
10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000 10000
1000000 1000000 1000000 1000000 1000000 1000000 1000000 1000000
1000000 1000000 1000000 1000000 1000000 1000000 1000000 1000000
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000
20000000 20000000 20000000 20000000 20000000 20000000 20000000 20000000
20000000 20000000 20000000 20000000 20000000 20000000 20000000 20000000
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
d c f e 9 8 b a 4 5 6 7 0 1 2 3

// ==== tests/tb_bench.sv ====
`timescale 1ns/100ps

module tb_bench;

    localparam int RUN_WORDS    = 273;
    localparam int VEC_WORDS    = 2 * RUN_WORDS;
    localparam int A_OFS        = 1;
    localparam int B_OFS        = 129;
    localparam int EXP_OFS      = 257;
    localparam int ACK_TIMEOUT  = 8;
    localparam int RUN_TIMEOUT  = 100;
    localparam int QUIET_CYCLES = 30;
    localparam logic [bench_pkg::WB_ADR_W-1:0] CTRL_ADR = 9'h100;

    logic               ap_clk;
    logic               rst;
    logic               ap_start;
    bench_pkg::wb_req_t wb_req;
    bench_pkg::wb_rsp_t wb_rsp;
    logic               ap_done;
    logic [3:0]         data_out;
    logic               data_valid;

    logic [31:0] vec_mem [0:VEC_WORDS-1];
    logic [31:0] lfsr;
    logic [31:0] rd_word;

    bench_top u_bench_top (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .ap_start  (ap_start),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .ap_done   (ap_done),
        .data_out  (data_out),
        .data_valid(data_valid)
    );

    always #5 ap_clk = ~ap_clk;

    //##################################################
    // checking and helpers
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string what);
        $display("error at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic idle_gap();
        int gap;
        lfsr = lfsr_step(lfsr);
        gap = int'(lfsr[0]);
        lfsr = lfsr_step(lfsr);
        gap = gap + 2 * int'(lfsr[0]);
        repeat (gap) @(negedge ap_clk);
    endtask

    function automatic logic [bench_pkg::WB_ADR_W-1:0] bank_adr(input logic b_mat,
                                                               input int lane, input int idx);
        return {1'b0, b_mat, lane[2:0], idx[3:0]};
    endfunction

    // one classic cycle, called on a falling edge
    task automatic wb_transfer(input logic we, input logic [bench_pkg::WB_ADR_W-1:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        waited = 0;
        @(negedge ap_clk);
        while (!wb_rsp.ack)
        begin
            waited++;
            if (waited >= ACK_TIMEOUT)
                fail_run("no Wishbone ack within the timeout");
            @(negedge ap_clk);
        end
        check_equal(32'(waited), 32'd0, "ack latency");
        rdat = wb_rsp.dat;
        wb_req = '0;
        @(negedge ap_clk);
        check_equal(32'(wb_rsp.ack), 32'd0, "second ack for one request");
        idle_gap();
    endtask

    task automatic wb_write(input logic [bench_pkg::WB_ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_transfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [bench_pkg::WB_ADR_W-1:0] adr, output logic [31:0] dat);
        wb_transfer(1'b0, adr, 32'd0, dat);
    endtask

    //##################################################
    // vector handling
    // expected nibble from the products of the enabled lanes
    task automatic check_vectors(input int base);
        logic [31:0] prod;
        logic [7:0]  byte_acc;
        logic [3:0]  nib;
        for (int i = 0; i < bench_pkg::BANK_DEPTH; i++)
        begin
            nib = '0;
            for (int l = 0; l < bench_pkg::LANES; l++)
            begin
                if (vec_mem[base][l])
                begin
                    prod = vec_mem[base + A_OFS + l * bench_pkg::BANK_DEPTH + i] *
                           vec_mem[base + B_OFS + l * bench_pkg::BANK_DEPTH + i];
                    byte_acc = prod[7:0] ^ prod[15:8] ^ prod[23:16] ^ prod[31:24];
                    nib = nib ^ byte_acc[7:4] ^ byte_acc[3:0];
                end
            end
            check_equal(32'(nib), vec_mem[base + EXP_OFS + i],
                        $sformatf("vector file nibble %0d", i));
        end
    endtask

    task automatic load_run(input int base);
        logic [31:0] rd;
        int          ofs;
        wb_write(CTRL_ADR, vec_mem[base]);
        for (int m = 0; m < 2; m++)
            for (int l = 0; l < bench_pkg::LANES; l++)
                for (int i = 0; i < bench_pkg::BANK_DEPTH; i++)
                begin
                    ofs = (m == 0 ? A_OFS : B_OFS) + l * bench_pkg::BANK_DEPTH + i;
                    wb_write(bank_adr(m[0], l, i), vec_mem[base + ofs]);
                end
        // readback
        wb_read(CTRL_ADR, rd);
        check_equal(rd, vec_mem[base] & 32'h0000_00ff, "mask readback");
        for (int m = 0; m < 2; m++)
            for (int l = 0; l < bench_pkg::LANES; l++)
                for (int i = 0; i < bench_pkg::BANK_DEPTH; i++)
                begin
                    ofs = (m == 0 ? A_OFS : B_OFS) + l * bench_pkg::BANK_DEPTH + i;
                    wb_read(bank_adr(m[0], l, i), rd);
                    check_equal(rd, vec_mem[base + ofs],
                                $sformatf("matrix %0d lane %0d index %0d readback", m, l, i));
                end
    endtask

    //##################################################
    // one kernel run that may be poked while busy
    task automatic run_kernel(input int exp_base, input int exp_count, input bit disturb);
        int valid_count;
        int cycles;
        bit done_seen;
        bit last_valid;
        valid_count = 0;
        cycles = 0;
        done_seen = 1'b0;
        last_valid = 1'b0;
        ap_start = 1'b1;
        @(negedge ap_clk);
        ap_start = 1'b0;
        fork
            begin
                while (!done_seen)
                begin
                    @(negedge ap_clk);
                    cycles++;
                    if (data_valid)
                    begin
                        if (valid_count >= exp_count)
                            fail_run("more data_valid cycles than expected");
                        if (valid_count > 0 && !last_valid)
                            fail_run("data_valid cycles are not consecutive");
                        check_equal(32'(data_out), vec_mem[exp_base + valid_count],
                                    $sformatf("signature %0d", valid_count));
                        valid_count++;
                    end
                    last_valid = data_valid;
                    if (ap_done)
                        done_seen = 1'b1;
                    else if (cycles >= RUN_TIMEOUT)
                        fail_run("no ap_done within the timeout");
                end
            end
            begin
                if (disturb)
                begin
                    repeat (2) @(negedge ap_clk);
                    ap_start = 1'b1;
                    @(negedge ap_clk);
                    ap_start = 1'b0;
                    wb_write(bank_adr(1'b0, 0, 0), 32'hdead_beef);
                    wb_write(CTRL_ADR, 32'h0);
                end
            end
        join
        check_equal(32'(valid_count), 32'(exp_count), "data_valid count");
        // nothing more may follow the done pulse
        repeat (QUIET_CYCLES)
        begin
            @(negedge ap_clk);
            check_equal({30'd0, data_valid, ap_done}, 32'd0, "activity after ap_done");
        end
    endtask

    initial
    begin
        ap_clk   = 1'b0;
        rst      = 1'b1;
        ap_start = 1'b0;
        wb_req   = '0;
        lfsr     = 32'h23947a9b;
        $readmemh("tests/bench_vectors.hex", vec_mem);
        repeat (10) @(negedge ap_clk);
        rst = 1'b0;

        // full mask, busy-time writes and a stray start
        check_vectors(0);
        load_run(0);
        run_kernel(EXP_OFS, bench_pkg::BANK_DEPTH, 1'b1);
        wb_read(bank_adr(1'b0, 0, 0), rd_word);
        check_equal(rd_word, vec_mem[A_OFS], "A word after write while busy");
        wb_read(CTRL_ADR, rd_word);
        check_equal(rd_word, vec_mem[0] & 32'h0000_00ff, "mask after write while busy");

        // partial mask
        check_vectors(RUN_WORDS);
        load_run(RUN_WORDS);
        run_kernel(RUN_WORDS + EXP_OFS, bench_pkg::BANK_DEPTH, 1'b0);

        // all lanes off but done still expected
        wb_write(CTRL_ADR, 32'h0);
        run_kernel(0, 0, 1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== design/bench_top.sv ====
`timescale 1ns/100ps

module bench_top #(
    parameter int DEPTH        = bench_pkg::BANK_DEPTH,
    // bank read and multiply sit ahead of the fold tree
    parameter int DRAIN_CYCLES = bench_pkg::FOLD_LATENCY + 2
) (
    input  logic              ap_clk,
    input  logic              rst,
    input  logic              ap_start,
    input  bench_pkg::wb_req_t wb_req,
    output bench_pkg::wb_rsp_t wb_rsp,
    output logic              ap_done,
    output logic [3:0]        data_out,
    output logic              data_valid
);

    bench_pkg::bank_rd_t    bank_rd;
    bench_pkg::lane_out_t   bank_lanes;
    bench_pkg::lane_words_t bank_b_words;
    bench_pkg::lane_out_t   lane_prod;
    logic                   busy;
    logic                   count_load;
    logic                   count_en;
    logic                   count_zero;
    logic [bench_pkg::IDX_W:0] count_value;

    dataset_banks #(
        .DEPTH(DEPTH)
    ) u_dataset_banks (
        .ap_clk (ap_clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .rd     (bank_rd),
        .lanes  (bank_lanes),
        .b_words(bank_b_words)
    );

    run_fsm #(
        .DEPTH       (DEPTH),
        .DRAIN_CYCLES(DRAIN_CYCLES)
    ) u_run_fsm (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .ap_start   (ap_start),
        .count_zero (count_zero),
        .count_load (count_load),
        .count_value(count_value),
        .count_en   (count_en),
        .rd         (bank_rd),
        .busy       (busy),
        .ap_done    (ap_done)
    );

    step_counter u_step_counter (
        .ap_clk(ap_clk),
        .rst   (rst),
        .load  (count_load),
        .value (count_value),
        .en    (count_en),
        .zero  (count_zero)
    );

    lane_multiply u_lane_multiply (
        .ap_clk (ap_clk),
        .rst    (rst),
        .a_in   (bank_lanes),
        .b_words(bank_b_words),
        .prod   (lane_prod)
    );

    xor_fold_tree u_xor_fold_tree (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .prod      (lane_prod),
        .data_out  (data_out),
        .data_valid(data_valid)
    );

endmodule

// ==== design/xor_fold_tree.sv ====
`timescale 1ns/100ps

module xor_fold_tree (
    input  logic                 ap_clk,
    input  logic                 rst,
    input  bench_pkg::lane_out_t prod,
    output logic [3:0]           data_out,
    output logic                 data_valid
);

    // heap layout with node n fed from 2n and 2n+1 and lanes as leaves
    localparam int NODES = 2 * bench_pkg::LANES;

    logic [7:0]       node_byte [1:NODES-1];
    logic [NODES-1:1] node_vld;

    function automatic logic [7:0] byte_fold(input bench_pkg::word_t w);
        logic [7:0] acc;
        acc = '0;
        for (int b = 0; b < bench_pkg::WORD_W / 8; b++)
            acc = acc ^ w[8*b +: 8];
        return acc;
    endfunction

    // pass the valid one, xor two valid ones, else zero
    function automatic logic [7:0] sel_xor(
        input logic [7:0] a,
        input logic       va,
        input logic [7:0] b,
        input logic       vb
    );
        case ({vb, va})
            2'b01:   return a;
            2'b10:   return b;
            2'b11:   return a ^ b;
            default: return 8'h00;
        endcase
    endfunction

    //##################################################
    // stage 1 on the leaves, stages 2 to 4 on the inner nodes
    always_ff @(posedge ap_clk)
    begin
        for (int l = 0; l < bench_pkg::LANES; l++)
            node_byte[bench_pkg::LANES + l] <= byte_fold(prod.words.w[l]);
        for (int n = 1; n < bench_pkg::LANES; n++)
        begin
            node_byte[n] <= sel_xor(node_byte[2*n], node_vld[2*n],
                                    node_byte[2*n+1], node_vld[2*n+1]);
        end
        // stage 5, byte to nibble
        data_out <= node_byte[1][7:4] ^ node_byte[1][3:0];
    end

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            node_vld   <= '0;
            data_valid <= 1'b0;
        end
        else
        begin
            node_vld[NODES-1:bench_pkg::LANES] <= prod.strb;
            for (int n = 1; n < bench_pkg::LANES; n++)
                node_vld[n] <= node_vld[2*n] | node_vld[2*n+1];
            data_valid <= node_vld[1];
        end
    end

endmodule

// ==== design/lane_multiply.sv ====
`timescale 1ns/100ps

module lane_multiply (
    input  logic                   ap_clk,
    input  logic                   rst,
    input  bench_pkg::lane_out_t   a_in,
    input  bench_pkg::lane_words_t b_words,
    output bench_pkg::lane_out_t   prod
);

    bench_pkg::lane_mask_t  strb_q;
    bench_pkg::lane_words_t words_q;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
            strb_q <= '0;
        else
            strb_q <= a_in.strb;
    end

    // low 32 bits only and zero for disabled lanes
    always_ff @(posedge ap_clk)
    begin
        for (int l = 0; l < bench_pkg::LANES; l++)
        begin
            if (a_in.strb[l])
                words_q.w[l] <= a_in.words.w[l] * b_words.w[l];
            else
                words_q.w[l] <= '0;
        end
    end

    assign prod = '{strb: strb_q, words: words_q};

endmodule

// ==== design/step_counter.sv ====
`timescale 1ns/100ps

module step_counter (
    input  logic                      ap_clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic [bench_pkg::IDX_W:0] value,
    input  logic                      en,
    output logic                      zero
);

    logic [bench_pkg::IDX_W:0] count;

    // zero is registered alongside the count
    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            count <= '0;
            zero  <= 1'b1;
        end
        else if (load)
        begin
            count <= value;
            zero  <= (value == '0);
        end
        else if (en && !zero)
        begin
            count <= count - 1'b1;
            zero  <= (count == 1);
        end
    end

endmodule

// ==== design/run_fsm.sv ====
`timescale 1ns/100ps

module run_fsm #(
    parameter int DEPTH        = 16,
    parameter int DRAIN_CYCLES = 7
) (
    input  logic                      ap_clk,
    input  logic                      rst,
    input  logic                      ap_start,
    input  logic                      count_zero,
    output logic                      count_load,
    output logic [bench_pkg::IDX_W:0] count_value,
    output logic                      count_en,
    output bench_pkg::bank_rd_t       rd,
    output logic                      busy,
    output logic                      ap_done
);

    localparam int CNT_W = bench_pkg::IDX_W + 1;
    localparam logic [CNT_W-1:0] SWEEP_LOAD = CNT_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] DRAIN_LOAD = CNT_W'(DRAIN_CYCLES - 1);

    bench_pkg::run_state_t       state;
    logic [bench_pkg::IDX_W-1:0] rd_index;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
            state <= bench_pkg::RUN_IDLE;
        else
        begin
            case (state)
                bench_pkg::RUN_IDLE:  if (ap_start) state <= bench_pkg::RUN_READ;
                bench_pkg::RUN_READ:  if (count_zero) state <= bench_pkg::RUN_DRAIN;
                bench_pkg::RUN_DRAIN: if (count_zero) state <= bench_pkg::RUN_IDLE;
                default:              state <= bench_pkg::RUN_IDLE;
            endcase
        end
    end

    // index runs up while the counter runs down
    always_ff @(posedge ap_clk)
    begin
        if (rst || state == bench_pkg::RUN_IDLE)
            rd_index <= '0;
        else if (state == bench_pkg::RUN_READ)
            rd_index <= rd_index + 1'b1;
    end

    assign count_load  = (state == bench_pkg::RUN_IDLE && ap_start) ||
                         (state == bench_pkg::RUN_READ && count_zero);
    assign count_value = (state == bench_pkg::RUN_IDLE) ? SWEEP_LOAD : DRAIN_LOAD;
    assign count_en    = (state != bench_pkg::RUN_IDLE);

    assign rd      = '{en: state == bench_pkg::RUN_READ, index: rd_index};
    assign busy    = (state != bench_pkg::RUN_IDLE);
    assign ap_done = (state == bench_pkg::RUN_DRAIN) && count_zero;

endmodule

// ==== design/dataset_banks.sv ====
`timescale 1ns/100ps

module dataset_banks #(
    parameter int DEPTH = 16
) (
    input  logic                   ap_clk,
    input  logic                   rst,
    input  bench_pkg::wb_req_t     wb_req,
    output bench_pkg::wb_rsp_t     wb_rsp,
    input  logic                   busy,
    input  bench_pkg::bank_rd_t    rd,
    output bench_pkg::lane_out_t   lanes,
    output bench_pkg::lane_words_t b_words
);

    logic                          wb_hit;
    logic                          wb_wr;
    logic [bench_pkg::IDX_W-1:0]   wb_idx;
    logic [bench_pkg::LANE_W-1:0]  wb_lane;
    logic                          wb_mat;
    logic                          wb_ctrl;
    logic                          ack_q;
    bench_pkg::word_t              rsp_dat_q;
    bench_pkg::lane_mask_t         lane_mask;
    bench_pkg::lane_mask_t         rd_strb;
    bench_pkg::lane_words_t        a_words;
    bench_pkg::word_t              wb_a_word [bench_pkg::LANES];
    bench_pkg::word_t              wb_b_word [bench_pkg::LANES];

    //##################################################
    // wishbone decode
    assign wb_idx  = wb_req.adr[bench_pkg::IDX_W-1:0];
    assign wb_lane = wb_req.adr[bench_pkg::ADR_MAT_BIT-1:bench_pkg::IDX_W];
    assign wb_mat  = wb_req.adr[bench_pkg::ADR_MAT_BIT];
    assign wb_ctrl = wb_req.adr[bench_pkg::ADR_CTRL_BIT];

    // single ack per request and no writes while a run is busy
    assign wb_hit = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wb_wr  = wb_hit & wb_req.we & ~busy;

    always_ff @(posedge ap_clk)
    begin
        if (rst)
        begin
            ack_q     <= 1'b0;
            lane_mask <= '0;
        end
        else
        begin
            ack_q <= wb_hit;
            if (wb_wr && wb_ctrl)
                lane_mask <= wb_req.dat[bench_pkg::LANES-1:0];
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (wb_hit)
        begin
            if (wb_ctrl)
                rsp_dat_q <= bench_pkg::word_t'(lane_mask);
            else if (wb_mat)
                rsp_dat_q <= wb_b_word[wb_lane];
            else
                rsp_dat_q <= wb_a_word[wb_lane];
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rsp_dat_q};

    //##################################################
    // per-lane banks
    for (genvar l = 0; l < bench_pkg::LANES; l++)
    begin : g_lane
        bench_pkg::word_t a_bank [DEPTH];
        bench_pkg::word_t b_bank [DEPTH];

        always_ff @(posedge ap_clk)
        begin
            if (wb_wr && !wb_ctrl && wb_lane == l)
            begin
                if (wb_mat)
                    b_bank[wb_idx] <= wb_req.dat;
                else
                    a_bank[wb_idx] <= wb_req.dat;
            end
            if (rd.en)
            begin
                a_words.w[l] <= a_bank[rd.index];
                b_words.w[l] <= b_bank[rd.index];
            end
        end

        assign wb_a_word[l] = a_bank[wb_idx];
        assign wb_b_word[l] = b_bank[wb_idx];
    end

    // strobe lags the read by one cycle like the data
    always_ff @(posedge ap_clk)
    begin
        if (rst)
            rd_strb <= '0;
        else
            rd_strb <= lane_mask & {bench_pkg::LANES{rd.en}};
    end

    assign lanes = '{strb: rd_strb, words: a_words};

endmodule

// ==== design/bench_pkg.sv ====
package bench_pkg;

    //##################################################
    // sizes
    localparam int LANES        = 8;
    localparam int WORD_W       = 32;
    localparam int BANK_DEPTH   = 16;
    localparam int IDX_W        = $clog2(BANK_DEPTH);
    localparam int LANE_W       = $clog2(LANES);

    // wishbone word address fields from index up to control space
    localparam int ADR_MAT_BIT  = IDX_W + LANE_W;
    localparam int ADR_CTRL_BIT = ADR_MAT_BIT + 1;
    localparam int WB_ADR_W     = ADR_CTRL_BIT + 1;

    // lane products to data_out
    localparam int FOLD_LATENCY = 5;

    //##################################################
    // types
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LANES-1:0] lane_mask_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        word_t               dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic             en;
        logic [IDX_W-1:0] index;
    } bank_rd_t;

    // one word per lane with lane 0 in the low bits
    typedef struct packed {
        word_t [LANES-1:0] w;
    } lane_words_t;

    typedef struct packed {
        lane_mask_t  strb;
        lane_words_t words;
    } lane_out_t;

    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_READ,
        RUN_DRAIN
    } run_state_t;

endpackage
